//--- fifo_pkg.sv
package fifo_pkg;

  // Word width and FIFO depth
  localparam int DATA_WIDTH = 8;
  localparam int FIFO_DEPTH = 16;

  // RAM address, depth must be a power of two
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  // Almost thresholds in words
  localparam int FIFO_AFULL  = 12;
  localparam int FIFO_AEMPTY = 2;

  // One data word
  typedef logic [DATA_WIDTH-1:0] data_t;

  // RAM address without the wrap bit
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // Occupancy 0 to FIFO_DEPTH
  typedef logic [ADDR_WIDTH:0] count_t;

endpackage

//--- cdc_pkg.sv
package cdc_pkg;

  // Flops in each pointer synchronizer
  localparam int SYNC_STAGES = 2;

  // Pointer with wrap bit, binary or Gray
  typedef logic [fifo_pkg::ADDR_WIDTH:0] ptr_t;

  function automatic ptr_t bin2gray(input ptr_t bin);
    return (bin >> 1) ^ bin;
  endfunction

  function automatic ptr_t gray2bin(input ptr_t gray);
    ptr_t bin;
    bin[$bits(ptr_t)-1] = gray[$bits(ptr_t)-1];
    // Each binary bit folds in all Gray bits above it
    for (int i = $bits(ptr_t) - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

//--- fifo_ram_if.sv
`timescale 1ns/1ns

interface fifo_ram_if;

  // Write port, wr_clk domain
  logic            wr_en;
  fifo_pkg::addr_t wr_addr;
  fifo_pkg::data_t wr_data;

  // Read port, rd_clk domain
  logic            rd_en;
  fifo_pkg::addr_t rd_addr;
  fifo_pkg::data_t rd_data;

  // Write data comes from the top, not the controller
  modport wr_side (
    output wr_en,
    output wr_addr
  );

  modport rd_side (
    output rd_en,
    output rd_addr
  );

  modport ram (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_en,
    input  rd_addr,
    output rd_data
  );

endinterface

//--- dual_port_ram.sv
`timescale 1ns/1ns

module dual_port_ram (
  input logic   wr_clk,
  input logic   rd_clk,
  input logic   rd_rst_n,
  fifo_ram_if.ram mem
);

  fifo_pkg::data_t storage [fifo_pkg::FIFO_DEPTH];

  // Write port, enable already qualified by full
  always_ff @(posedge wr_clk) begin
    if (mem.wr_en) begin
      storage[mem.wr_addr] <= mem.wr_data;
    end
  end

  // Registered read, holds its value between reads
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      mem.rd_data <= '0;
    end else if (mem.rd_en) begin
      mem.rd_data <= storage[mem.rd_addr];
    end
  end

endmodule

//--- ptr_sync.sv
`timescale 1ns/1ns

module ptr_sync (
  input  logic          dst_clk,
  input  logic          dst_rst_n,
  input  cdc_pkg::ptr_t src_gray,
  output cdc_pkg::ptr_t dst_bin
);

  cdc_pkg::ptr_t sync_q [cdc_pkg::SYNC_STAGES];

  // Gray input changes one bit at a time, so each stage is safe to sample
  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) begin
      for (int i = 0; i < cdc_pkg::SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= src_gray;
      for (int i = 1; i < cdc_pkg::SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // Binary form for the occupancy subtraction
  assign dst_bin = cdc_pkg::gray2bin(sync_q[cdc_pkg::SYNC_STAGES-1]);

endmodule

//--- wr_ctrl.sv
`timescale 1ns/1ns

module wr_ctrl (
  input  logic          wr_clk,
  input  logic          wr_rst_n,
  input  logic          wr_en,
  input  cdc_pkg::ptr_t rd_ptr_sync,
  fifo_ram_if.wr_side   ram,
  output cdc_pkg::ptr_t wr_gray,
  output logic          full,
  output logic          afull
);

  cdc_pkg::ptr_t    wr_ptr;
  cdc_pkg::ptr_t    wr_ptr_nxt;
  fifo_pkg::count_t wr_count_nxt;
  logic             wr_vld;

  // Writes while full are dropped
  assign wr_vld = wr_en && !full;

  assign ram.wr_en   = wr_vld;
  assign ram.wr_addr = wr_ptr[fifo_pkg::ADDR_WIDTH-1:0];

  always_comb begin
    if (wr_vld) begin
      wr_ptr_nxt = wr_ptr + 1'b1;
    end else begin
      wr_ptr_nxt = wr_ptr;
    end
  end

  // Count seen from the write side, stale read pointer makes it high
  assign wr_count_nxt = fifo_pkg::count_t'(wr_ptr_nxt - rd_ptr_sync);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr <= '0;
    end else begin
      wr_ptr <= wr_ptr_nxt;
    end
  end

  // Gray copy is registered so only one bit moves per edge
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_gray <= '0;
    end else begin
      wr_gray <= cdc_pkg::bin2gray(wr_ptr_nxt);
    end
  end

  // Flags from the next pointer, so full rises on the filling write
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= (wr_count_nxt == fifo_pkg::count_t'(fifo_pkg::FIFO_DEPTH));
      afull <= (wr_count_nxt >= fifo_pkg::count_t'(fifo_pkg::FIFO_AFULL));
    end
  end

endmodule

//--- rd_ctrl.sv
`timescale 1ns/1ns

module rd_ctrl (
  input  logic          rd_clk,
  input  logic          rd_rst_n,
  input  logic          rd_en,
  input  cdc_pkg::ptr_t wr_ptr_sync,
  fifo_ram_if.rd_side   ram,
  output cdc_pkg::ptr_t rd_gray,
  output logic          empty,
  output logic          aempty
);

  cdc_pkg::ptr_t    rd_ptr;
  cdc_pkg::ptr_t    rd_ptr_nxt;
  fifo_pkg::count_t rd_count_nxt;
  logic             rd_vld;

  // Reads while empty are dropped
  assign rd_vld = rd_en && !empty;

  assign ram.rd_en   = rd_vld;
  assign ram.rd_addr = rd_ptr[fifo_pkg::ADDR_WIDTH-1:0];

  always_comb begin
    if (rd_vld) begin
      rd_ptr_nxt = rd_ptr + 1'b1;
    end else begin
      rd_ptr_nxt = rd_ptr;
    end
  end

  // Count seen from the read side, stale write pointer makes it low
  assign rd_count_nxt = fifo_pkg::count_t'(wr_ptr_sync - rd_ptr_nxt);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr <= '0;
    end else begin
      rd_ptr <= rd_ptr_nxt;
    end
  end

  // Registered Gray copy for the write domain
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_gray <= '0;
    end else begin
      rd_gray <= cdc_pkg::bin2gray(rd_ptr_nxt);
    end
  end

  // Both flags high out of reset
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= (rd_count_nxt == '0);
      aempty <= (rd_count_nxt <= fifo_pkg::count_t'(fifo_pkg::FIFO_AEMPTY));
    end
  end

endmodule

//--- async_fifo.sv
`timescale 1ns/1ns

module async_fifo (
  input  logic            wr_clk,
  input  logic            wr_rst_n,
  input  logic            wr_en,
  input  fifo_pkg::data_t wr_data,
  input  logic            rd_clk,
  input  logic            rd_rst_n,
  input  logic            rd_en,
  output fifo_pkg::data_t rd_data,
  output logic            full,
  output logic            afull,
  output logic            empty,
  output logic            aempty
);

  // Gray pointers leaving each domain
  cdc_pkg::ptr_t wr_gray;
  cdc_pkg::ptr_t rd_gray;

  // Binary pointers after crossing
  cdc_pkg::ptr_t wr_ptr_sync;
  cdc_pkg::ptr_t rd_ptr_sync;

  fifo_ram_if ram_bus ();

  assign ram_bus.wr_data = wr_data;
  assign rd_data         = ram_bus.rd_data;

  dual_port_ram u_ram (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .mem      (ram_bus.ram)
  );

  wr_ctrl u_wr_ctrl (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .rd_ptr_sync (rd_ptr_sync),
    .ram         (ram_bus.wr_side),
    .wr_gray     (wr_gray),
    .full        (full),
    .afull       (afull)
  );

  rd_ctrl u_rd_ctrl (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .wr_ptr_sync (wr_ptr_sync),
    .ram         (ram_bus.rd_side),
    .rd_gray     (rd_gray),
    .empty       (empty),
    .aempty      (aempty)
  );

  // Write pointer into the read domain
  ptr_sync u_wr_ptr_sync (
    .dst_clk   (rd_clk),
    .dst_rst_n (rd_rst_n),
    .src_gray  (wr_gray),
    .dst_bin   (wr_ptr_sync)
  );

  // Read pointer into the write domain
  ptr_sync u_rd_ptr_sync (
    .dst_clk   (wr_clk),
    .dst_rst_n (wr_rst_n),
    .src_gray  (rd_gray),
    .dst_bin   (rd_ptr_sync)
  );

endmodule

//--- async_fifo_assertions.sv
`timescale 1ns/1ns

module async_fifo_assertions (
  input logic          wr_clk,
  input logic          wr_rst_n,
  input logic          rd_clk,
  input logic          rd_rst_n,
  input logic          full,
  input logic          empty,
  input cdc_pkg::ptr_t wr_gray,
  input cdc_pkg::ptr_t rd_gray,
  input cdc_pkg::ptr_t wr_ptr_sync,
  input cdc_pkg::ptr_t rd_ptr_sync
);

  int fail_count = 0;

  fifo_pkg::count_t wr_side_count;
  fifo_pkg::count_t rd_side_count;

  assign wr_side_count = fifo_pkg::count_t'(cdc_pkg::gray2bin(wr_gray) - rd_ptr_sync);
  assign rd_side_count = fifo_pkg::count_t'(wr_ptr_sync - cdc_pkg::gray2bin(rd_gray));

  full_vs_count: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n) full |-> (wr_side_count != '0)
  ) else begin
    $error("full is high while the write-side count is zero");
    fail_count++;
  end

  empty_vs_count: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
      empty |-> (rd_side_count != fifo_pkg::count_t'(fifo_pkg::FIFO_DEPTH))
  ) else begin
    $error("empty is high while the read-side count shows a full FIFO");
    fail_count++;
  end

  // One bit per edge keeps each crossing safe
  wr_gray_step: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n) $countones(wr_gray ^ $past(wr_gray)) <= 1
  ) else begin
    $error("write Gray pointer changed more than one bit");
    fail_count++;
  end

  rd_gray_step: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) $countones(rd_gray ^ $past(rd_gray)) <= 1
  ) else begin
    $error("read Gray pointer changed more than one bit");
    fail_count++;
  end

  wr_hold_when_full: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n) $past(full) |-> (wr_gray == $past(wr_gray))
  ) else begin
    $error("write pointer moved while full was high");
    fail_count++;
  end

endmodule

bind async_fifo async_fifo_assertions u_fifo_assertions (
  .wr_clk      (wr_clk),
  .wr_rst_n    (wr_rst_n),
  .rd_clk      (rd_clk),
  .rd_rst_n    (rd_rst_n),
  .full        (full),
  .empty       (empty),
  .wr_gray     (wr_gray),
  .rd_gray     (rd_gray),
  .wr_ptr_sync (wr_ptr_sync),
  .rd_ptr_sync (rd_ptr_sync)
);

//--- tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
  output logic wr_clk,
  output logic rd_clk,
  output logic wr_rst_n,
  output logic rd_rst_n
);

  localparam int HALF_PERIOD  = 10;
  localparam int RD_SHIFT     = 7;
  localparam int RESET_CYCLES = 4;

  initial begin
    wr_clk = 1'b0;
    forever #HALF_PERIOD wr_clk = ~wr_clk;
  end

  // Same period, rd_clk lags by a few ns
  initial begin
    rd_clk = 1'b0;
    #RD_SHIFT;
    forever #HALF_PERIOD rd_clk = ~rd_clk;
  end

  initial begin
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge wr_clk);
    @(negedge wr_clk);
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;
  end

endmodule

//--- tb_async_fifo.sv
`timescale 1ns/1ns

module tb_async_fifo;

  localparam int NUM_STEPS     = 11;
  localparam int SETTLE_CYCLES = 6;
  localparam int RESET_TIMEOUT = 50;
  localparam int DRAIN_TIMEOUT = 200;

  typedef enum logic [1:0] {
    OP_WRITE,
    OP_READ,
    OP_CONC
  } op_t;

  typedef struct packed {
    op_t             op;
    logic [15:0]     len;
    fifo_pkg::data_t seed;
    logic            exp_full;
    logic            exp_afull;
    logic            exp_empty;
    logic            exp_aempty;
  } step_t;

  logic            wr_clk;
  logic            rd_clk;
  logic            wr_rst_n;
  logic            rd_rst_n;
  logic            wr_en;
  fifo_pkg::data_t wr_data;
  logic            rd_en;
  fifo_pkg::data_t rd_data;
  logic            full;
  logic            afull;
  logic            empty;
  logic            aempty;

  step_t           steps [NUM_STEPS];
  fifo_pkg::data_t ref_q [$];
  fifo_pkg::data_t rd_expect;
  int              cur_step;
  int              data_errors;
  int              flag_errors;
  int              timeouts;
  int              assert_errors;

  tb_clk_gen u_clk_gen (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .rd_rst_n (rd_rst_n)
  );

  async_fifo dut (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  task automatic check_data(input fifo_pkg::data_t actual, input fifo_pkg::data_t expected,
                            input string what);
    if (actual !== expected) begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
      data_errors++;
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("ERR %0t: %s is %b, expected %b", $time, what, actual, expected);
      flag_errors++;
    end
  endtask

  function automatic step_t make_step(input op_t op, input int len, input fifo_pkg::data_t seed,
                                      input logic f, input logic af, input logic e,
                                      input logic ae);
    step_t st;
    st.op         = op;
    st.len        = 16'(len);
    st.seed       = seed;
    st.exp_full   = f;
    st.exp_afull  = af;
    st.exp_empty  = e;
    st.exp_aempty = ae;
    return st;
  endfunction

  // Occupancy after each step is 2, 3, 12, 16, 0, 16, 0, 0, 3, 0, 0
  task automatic load_table();
    steps[0]  = make_step(OP_WRITE, 2, 8'h10, 1'b0, 1'b0, 1'b0, 1'b1);
    steps[1]  = make_step(OP_WRITE, 1, 8'h20, 1'b0, 1'b0, 1'b0, 1'b0);
    steps[2]  = make_step(OP_WRITE, 9, 8'h30, 1'b0, 1'b1, 1'b0, 1'b0);
    steps[3]  = make_step(OP_WRITE, 4, 8'h40, 1'b1, 1'b1, 1'b0, 1'b0);
    steps[4]  = make_step(OP_READ, 16, 8'h00, 1'b0, 1'b0, 1'b1, 1'b1);
    // Only 16 of the 20 writes fit
    steps[5]  = make_step(OP_WRITE, 20, 8'h50, 1'b1, 1'b1, 1'b0, 1'b0);
    steps[6]  = make_step(OP_READ, 16, 8'h00, 1'b0, 1'b0, 1'b1, 1'b1);
    // Reads while empty
    steps[7]  = make_step(OP_READ, 4, 8'h00, 1'b0, 1'b0, 1'b1, 1'b1);
    steps[8]  = make_step(OP_WRITE, 3, 8'h60, 1'b0, 1'b0, 1'b0, 1'b0);
    steps[9]  = make_step(OP_READ, 3, 8'h00, 1'b0, 1'b0, 1'b1, 1'b1);
    steps[10] = make_step(OP_CONC, 400, 8'h00, 1'b0, 1'b0, 1'b1, 1'b1);
  endtask

  task automatic write_cycle(input logic en, input fifo_pkg::data_t data);
    @(negedge wr_clk);
    wr_en   = en;
    wr_data = data;
    // full holds until the next rising edge
    if (en && !full) begin
      ref_q.push_back(data);
    end
  endtask

  task automatic read_cycle(input logic en);
    @(negedge rd_clk);
    check_data(rd_data, rd_expect, $sformatf("step %0d rd_data", cur_step));
    rd_en = en;
    if (en && !empty) begin
      if (ref_q.size() == 0) begin
        $display("ERR %0t: read accepted with no word left in the reference queue", $time);
        data_errors++;
      end else begin
        rd_expect = ref_q.pop_front();
      end
    end
  endtask

  task automatic check_flags(input string tag, input logic exp_full, input logic exp_afull,
                             input logic exp_empty, input logic exp_aempty);
    @(negedge wr_clk);
    check_flag(full, exp_full, {tag, " full"});
    check_flag(afull, exp_afull, {tag, " afull"});
    @(negedge rd_clk);
    check_flag(empty, exp_empty, {tag, " empty"});
    check_flag(aempty, exp_aempty, {tag, " aempty"});
  endtask

  task automatic settle();
    fork
      repeat (SETTLE_CYCLES) write_cycle(1'b0, wr_data);
      repeat (SETTLE_CYCLES) read_cycle(1'b0);
    join
  endtask

  task automatic wait_reset();
    int cycles;
    cycles = 0;
    while ((wr_rst_n !== 1'b1 || rd_rst_n !== 1'b1) && cycles < RESET_TIMEOUT) begin
      @(negedge wr_clk);
      cycles++;
    end
    if (wr_rst_n !== 1'b1 || rd_rst_n !== 1'b1) begin
      $display("Timeout: resets were not released within %0d cycles", RESET_TIMEOUT);
      timeouts++;
    end
  endtask

  task automatic run_concurrent(input int cycles);
    int guard;
    fork
      begin
        repeat (cycles) write_cycle($urandom % 2 == 1, fifo_pkg::data_t'($urandom));
        write_cycle(1'b0, '0);
      end
      begin
        repeat (cycles) read_cycle($urandom % 2 == 1);
        read_cycle(1'b0);
      end
    join
    // Drain whatever is left
    guard = 0;
    while (ref_q.size() != 0 && guard < DRAIN_TIMEOUT) begin
      read_cycle(1'b1);
      guard++;
    end
    if (ref_q.size() != 0) begin
      $display("Timeout: %0d words were still unread after the drain", ref_q.size());
      timeouts++;
    end
  endtask

  task automatic run_step(input step_t st);
    case (st.op)
      OP_WRITE: begin
        for (int i = 0; i < int'(st.len); i++) begin
          write_cycle(1'b1, fifo_pkg::data_t'(int'(st.seed) + i));
        end
      end
      OP_READ: begin
        repeat (st.len) read_cycle(1'b1);
      end
      default: begin
        run_concurrent(int'(st.len));
      end
    endcase
  endtask

  initial begin
    wr_en         = 1'b0;
    wr_data       = '0;
    rd_en         = 1'b0;
    rd_expect     = '0;
    cur_step      = -1;
    data_errors   = 0;
    flag_errors   = 0;
    timeouts      = 0;
    assert_errors = 0;
    void'($urandom(32'h2e44_26f5));
    load_table();
    wait_reset();
    if (timeouts == 0) begin
      check_flags("after reset", 1'b0, 1'b0, 1'b1, 1'b1);
    end
    for (int s = 0; s < NUM_STEPS && timeouts == 0; s++) begin
      cur_step = s;
      run_step(steps[s]);
      settle();
      check_flags($sformatf("step %0d", s), steps[s].exp_full, steps[s].exp_afull,
                  steps[s].exp_empty, steps[s].exp_aempty);
    end
    assert_errors = dut.u_fifo_assertions.fail_count;
    $display("Errors: %0d data, %0d flag, %0d timeout, %0d assertion",
             data_errors, flag_errors, timeouts, assert_errors);
    if (data_errors + flag_errors + timeouts + assert_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- async_fifo.f
fifo_pkg.sv
cdc_pkg.sv
fifo_ram_if.sv
dual_port_ram.sv
ptr_sync.sv
wr_ctrl.sv
rd_ctrl.sv
async_fifo.sv
async_fifo_assertions.sv
tb_clk_gen.sv
tb_async_fifo.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the dual-clock FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_async_fifo -f async_fifo.f -o sim_async_fifo > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/sim_async_fifo > sim.log 2>&1 \
  || echo "Simulator exited with an error status"

grep -qx "Simulation passed" sim.log \
  && { cat sim.log; echo "PASS"; exit 0; } \
  || { cat sim.log; echo "FAIL"; exit 1; }
